// File: hw/rvfi_trace_pkg.sv
// Stage index enum, debug cause enum and record structs for the retirement trace unit

package rvfi_trace_pkg;

  ////////////////////////////////////////
  // Enumerations
  ////////////////////////////////////////

  // Index of each pipeline stage in the tracker record array
  typedef enum logic [1:0] {
    STAGE_IF = 2'd0,
    STAGE_ID = 2'd1,
    STAGE_EX = 2'd2,
    STAGE_WB = 2'd3
  } stage_e;

  // Reason for entering debug mode, as reported on rvfi_dbg
  typedef enum logic [2:0] {
    DBG_CAUSE_NONE    = 3'd0,
    DBG_CAUSE_EBREAK  = 3'd1,
    DBG_CAUSE_TRIGGER = 3'd2,
    DBG_CAUSE_HALTREQ = 3'd3
  } dbg_cause_e;

  ////////////////////////////////////////
  // Records
  ////////////////////////////////////////

  // One cycle of captured events
  // At most one of irq, dbg and exc is set, and any follows them
  typedef struct packed {
    logic       irq;
    logic [4:0] irq_id;
    logic       dbg;
    dbg_cause_e dbg_cause;
    logic       exc;
    logic [5:0] exc_cause;
    logic       any;
  } event_t;

  // Trap record carried with a retiring instruction
  typedef struct packed {
    logic       exception;
    logic [5:0] exception_cause;
    dbg_cause_e debug_cause;
  } rvfi_trap_t;

  // Interrupt record, set on the first instruction of a trap handler
  // The interrupt bit tells an asynchronous interrupt from entry after an exception
  typedef struct packed {
    logic       intr;
    logic       interrupt;
    logic [4:0] cause;
  } rvfi_intr_t;

  // Per-stage record
  // With valid low, the IF record may still hold a pending irq or debug mark
  typedef struct packed {
    logic       valid;
    logic [31:0] pc;
    logic       intr;
    logic [4:0] irq_id;
    rvfi_trap_t trap;
    dbg_cause_e dbg;
  } stage_rec_t;

endpackage

// File: hw/rvfi_event_capture.sv
// Event capture module registering interrupt, debug and exception pulses into one event record

`timescale 1ns/10ps

module rvfi_event_capture import rvfi_trace_pkg::*; #(
  parameter int DEBUG = 1
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Interrupt acknowledge from the controller
  input  logic       irq_ack_i,
  input  logic [4:0] irq_id_i,

  // Debug entry acknowledge
  input  logic       dbg_ack_i,
  input  dbg_cause_e dbg_cause_i,

  // Exception taken on the instruction in WB
  input  logic       exc_i,
  input  logic [5:0] exc_cause_i,

  output event_t     evt_o
);

  // Debug acknowledge after the DEBUG qualification
  logic   dbg_ack_en;
  event_t evt_d;
  event_t evt_q;

  // Debug tracking can be left out of the build entirely
  assign dbg_ack_en = (DEBUG != 0) && dbg_ack_i;

  ////////////////////////////////////////
  // Event selection
  ////////////////////////////////////////

  // Only one event survives per cycle
  // An exception wins since it belongs to the oldest instruction
  always_comb begin
    evt_d = '0;
    if (exc_i) begin
      evt_d.exc       = 1'b1;
      evt_d.exc_cause = exc_cause_i;
    end else if (dbg_ack_en) begin
      evt_d.dbg       = 1'b1;
      evt_d.dbg_cause = dbg_cause_i;
    end else if (irq_ack_i) begin
      evt_d.irq    = 1'b1;
      evt_d.irq_id = irq_id_i;
    end
    // Summary bit lets the tracker stall without decoding the record
    evt_d.any = exc_i | dbg_ack_en | irq_ack_i;
  end

  ////////////////////////////////////////
  // Event register
  ////////////////////////////////////////

  // Loaded every cycle, so a single pulse gives a record that lives one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_q <= '0;
    end else begin
      evt_q <= evt_d;
    end
  end

  assign evt_o = evt_q;

endmodule

// File: hw/rvfi_stage_tracker.sv
// Stage tracker module holding one record per pipeline stage with event marks and flushes

`timescale 1ns/10ps

module rvfi_stage_tracker import rvfi_trace_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // All stages advance on this cycle
  input  logic        step_i,

  // New instruction entering IF on the step
  input  logic        fetch_i,
  input  logic [31:0] fetch_pc_i,

  // Registered events from the capture stage
  input  event_t      evt_i,

  // Strobe and record of the instruction leaving WB
  output logic        retire_o,
  output stage_rec_t  wb_rec_o
);

  stage_rec_t rec_q [4];
  stage_rec_t rec_d [4];

  ////////////////////////////////////////
  // Next-state logic
  ////////////////////////////////////////

  always_comb begin
    rec_d = rec_q;

    if (evt_i.any) begin
      // Events take priority and the step of this cycle is dropped
      if (evt_i.exc) begin
        // The faulting instruction stays in WB and carries the trap
        // Everything younger is discarded along with any pending mark
        if (rec_q[STAGE_WB].valid) begin
          rec_d[STAGE_WB].trap.exception       = 1'b1;
          rec_d[STAGE_WB].trap.exception_cause = evt_i.exc_cause;
          rec_d[STAGE_IF]                      = '0;
          rec_d[STAGE_ID].valid                = 1'b0;
          rec_d[STAGE_EX].valid                = 1'b0;
        end
      end else begin
        // Interrupt and debug entry flush ID, EX and WB
        rec_d[STAGE_ID].valid = 1'b0;
        rec_d[STAGE_EX].valid = 1'b0;
        rec_d[STAGE_WB].valid = 1'b0;
        // Mark lands in IF, as a pending mark when IF is empty
        if (evt_i.irq) begin
          rec_d[STAGE_IF].intr   = 1'b1;
          rec_d[STAGE_IF].irq_id = evt_i.irq_id;
        end
        if (evt_i.dbg) begin
          rec_d[STAGE_IF].dbg = evt_i.dbg_cause;
        end
      end
    end else if (step_i) begin
      // Plain shift toward WB
      rec_d[STAGE_WB] = rec_q[STAGE_EX];
      rec_d[STAGE_EX] = rec_q[STAGE_ID];
      // An empty IF passes a clean bubble so its marks do not travel on
      rec_d[STAGE_ID] = rec_q[STAGE_IF].valid ? rec_q[STAGE_IF] : stage_rec_t'('0);

      // Pending marks in an empty IF wait for the next fetched instruction
      rec_d[STAGE_IF]       = rec_q[STAGE_IF].valid ? stage_rec_t'('0) : rec_q[STAGE_IF];
      rec_d[STAGE_IF].valid = fetch_i;
      if (fetch_i) begin
        rec_d[STAGE_IF].pc = fetch_pc_i;
      end
    end
  end

  ////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rec_q <= '{default: '0};
    end else begin
      rec_q <= rec_d;
    end
  end

  // WB record retires on the step edge itself
  // The report adds the register stage, so this strobe stays combinational
  assign retire_o = step_i && !evt_i.any && rec_q[STAGE_WB].valid;
  assign wb_rec_o = rec_q[STAGE_WB];

endmodule

// File: hw/rvfi_retire_report.sv
// Retirement report module forming the registered RVFI-style report and the post-trap interrupt record

`timescale 1ns/10ps

module rvfi_retire_report import rvfi_trace_pkg::*; #(
  parameter int DEBUG = 1
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Retirement strobe and record from WB
  input  logic        retire_i,
  input  stage_rec_t  rec_i,

  // Retirement report
  output logic        rvfi_valid_o,
  output logic [31:0] rvfi_pc_o,
  output rvfi_trap_t  rvfi_trap_o,
  output rvfi_intr_t  rvfi_intr_o,
  output dbg_cause_e  rvfi_dbg_o
);

  logic        valid_q;
  logic [31:0] pc_q;
  rvfi_trap_t  trap_q;
  rvfi_intr_t  intr_q;
  rvfi_intr_t  intr_d;
  dbg_cause_e  dbg_q;

  // Set while the last retired instruction took an exception
  logic        exc_seen_q;
  // Only the low bits fit the interrupt cause field
  logic [4:0]  exc_cause_q;

  ////////////////////////////////////////
  // Interrupt record
  ////////////////////////////////////////

  // An asynchronous interrupt on this instruction beats exception entry
  always_comb begin
    intr_d = '0;
    if (rec_i.intr) begin
      intr_d.intr      = 1'b1;
      intr_d.interrupt = 1'b1;
      intr_d.cause     = rec_i.irq_id;
    end else if (exc_seen_q) begin
      // First instruction after a trapped one is the handler entry
      intr_d.intr      = 1'b1;
      intr_d.interrupt = 1'b0;
      intr_d.cause     = exc_cause_q;
    end
  end

  ////////////////////////////////////////
  // Report registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      pc_q        <= '0;
      trap_q      <= '0;
      intr_q      <= '0;
      dbg_q       <= DBG_CAUSE_NONE;
      exc_seen_q  <= 1'b0;
      exc_cause_q <= '0;
    end else begin
      // Valid is high for exactly one cycle per retirement
      valid_q <= retire_i;
      if (retire_i) begin
        pc_q        <= rec_i.pc;
        trap_q      <= rec_i.trap;
        intr_q      <= intr_d;
        dbg_q       <= rec_i.dbg;
        // Sticky flag tracks only the most recent retirement
        exc_seen_q  <= rec_i.trap.exception;
        exc_cause_q <= rec_i.trap.exception_cause[4:0];
      end
    end
  end

  assign rvfi_valid_o = valid_q;
  assign rvfi_pc_o    = pc_q;
  assign rvfi_trap_o  = trap_q;
  assign rvfi_intr_o  = intr_q;
  // Without debug support the cause never leaves NONE
  assign rvfi_dbg_o   = (DEBUG != 0) ? dbg_q : DBG_CAUSE_NONE;

endmodule

// File: hw/rvfi_trace_top.sv
// Top level of the retirement trace unit connecting event capture, stage tracker and retire report

`timescale 1ns/10ps

module rvfi_trace_top import rvfi_trace_pkg::*; #(
  parameter int DEBUG = 1
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Pipeline progress and fetch
  input  logic        step_i,
  input  logic        fetch_i,
  input  logic [31:0] fetch_pc_i,

  // Event pulses
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  input  logic        dbg_ack_i,
  input  dbg_cause_e  dbg_cause_i,
  input  logic        exc_i,
  input  logic [5:0]  exc_cause_i,

  // Retirement report
  output logic        rvfi_valid_o,
  output logic [31:0] rvfi_pc_o,
  output rvfi_trap_t  rvfi_trap_o,
  output rvfi_intr_t  rvfi_intr_o,
  output dbg_cause_e  rvfi_dbg_o
);

  event_t     evt;
  logic       retire;
  stage_rec_t wb_rec;

  // Input side
  rvfi_event_capture #(
    .DEBUG (DEBUG)
  ) u_event_capture (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .dbg_ack_i   (dbg_ack_i),
    .dbg_cause_i (dbg_cause_i),
    .exc_i       (exc_i),
    .exc_cause_i (exc_cause_i),
    .evt_o       (evt)
  );

  // Per-stage records
  rvfi_stage_tracker u_stage_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step_i     (step_i),
    .fetch_i    (fetch_i),
    .fetch_pc_i (fetch_pc_i),
    .evt_i      (evt),
    .retire_o   (retire),
    .wb_rec_o   (wb_rec)
  );

  // Output side
  rvfi_retire_report #(
    .DEBUG (DEBUG)
  ) u_retire_report (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .retire_i     (retire),
    .rec_i        (wb_rec),
    .rvfi_valid_o (rvfi_valid_o),
    .rvfi_pc_o    (rvfi_pc_o),
    .rvfi_trap_o  (rvfi_trap_o),
    .rvfi_intr_o  (rvfi_intr_o),
    .rvfi_dbg_o   (rvfi_dbg_o)
  );

endmodule

// File: testbench/rvfi_trace_assertions.sv
// Concurrent retirement-rule checker and its bind to the trace unit top level

`timescale 1ns/10ps

module rvfi_trace_assertions import rvfi_trace_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       irq_ack_i,
  input logic       dbg_ack_i,
  input logic       exc_i,
  input logic       rvfi_valid_i,
  input rvfi_trap_t rvfi_trap_i,
  input rvfi_intr_t rvfi_intr_i,
  input dbg_cause_e rvfi_dbg_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  logic [2:0] dbg_pending_q;
  logic [4:0] exc_cause_q;
  logic       dbg_inc;
  logic       dbg_dec;

  // An exception in the same cycle wins over the debug acknowledge
  assign dbg_inc = dbg_ack_i && !exc_i;
  assign dbg_dec = rvfi_valid_i && (rvfi_dbg_i != DBG_CAUSE_NONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_pending_q <= '0;
      exc_cause_q   <= '0;
    end else begin
      dbg_pending_q <= dbg_pending_q + 3'(dbg_inc) - 3'(dbg_dec);
      // Cause of the last retired exception, cut to the interrupt cause width
      if (rvfi_valid_i && rvfi_trap_i.exception) begin
        exc_cause_q <= rvfi_trap_i.exception_cause[4:0];
      end
    end
  end

  ////////////////////////////////////////
  // Retirement rules
  ////////////////////////////////////////

  // The report of the acknowledge edge itself is skipped, hence the two-cycle gap
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_ack_i && !exc_i && !dbg_ack_i |-> ##2 rvfi_valid_i [->1] ##0
      (rvfi_intr_i.intr && rvfi_intr_i.interrupt))
    else begin
      fail_count++;
      $error("interrupt acknowledge not followed by an asynchronous interrupt record");
    end

  // Handler entry after a trap; an interrupt on that instruction takes precedence
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i && rvfi_trap_i.exception |=> rvfi_valid_i [->1] ##0
      (rvfi_intr_i.intr && (rvfi_intr_i.interrupt || rvfi_intr_i.cause == exc_cause_q)))
    else begin
      fail_count++;
      $error("retired exception not followed by a matching exception-entry record");
    end

  // A debug cause needs an acknowledge that has not been used up yet
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i && (rvfi_dbg_i != DBG_CAUSE_NONE) |-> dbg_pending_q != 3'd0)
    else begin
      fail_count++;
      $error("debug cause reported without an outstanding debug acknowledge");
    end

endmodule

bind rvfi_trace_top rvfi_trace_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .irq_ack_i    (irq_ack_i),
  .dbg_ack_i    (dbg_ack_i),
  .exc_i        (exc_i),
  .rvfi_valid_i (rvfi_valid_o),
  .rvfi_trap_i  (rvfi_trap_o),
  .rvfi_intr_i  (rvfi_intr_o),
  .rvfi_dbg_i   (rvfi_dbg_o)
);

// File: testbench/rvfi_trace_tb.sv
// Testbench for the retirement trace unit with clock, reset, stimulus table, checks and watchdog

`timescale 1ns/10ps

module rvfi_trace_tb import rvfi_trace_pkg::*; ();

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 5;
  localparam int MARGIN_CYCLES = 20;

  // Event pulse driven by a table row, with its cause in the code column
  typedef enum logic [1:0] {EV_NONE, EV_IRQ, EV_DBG, EV_EXC} ev_kind_e;

  // Stimulus for one cycle and the report expected after the edge that samples it
  typedef struct packed {
    logic        step;
    logic        fetch;
    logic [31:0] pc;
    ev_kind_e    kind;
    logic [5:0]  code;
    logic        exp_valid;
    logic [31:0] exp_pc;
    rvfi_trap_t  exp_trap;
    rvfi_intr_t  exp_intr;
    dbg_cause_e  exp_dbg;
  } row_t;

  logic        clk_i;
  logic        rst_ni;
  logic        step_i;
  logic        fetch_i;
  logic [31:0] fetch_pc_i;
  logic        irq_ack_i;
  logic [4:0]  irq_id_i;
  logic        dbg_ack_i;
  dbg_cause_e  dbg_cause_i;
  logic        exc_i;
  logic [5:0]  exc_cause_i;
  logic        rvfi_valid_o;
  logic [31:0] rvfi_pc_o;
  rvfi_trap_t  rvfi_trap_o;
  rvfi_intr_t  rvfi_intr_o;
  dbg_cause_e  rvfi_dbg_o;

  row_t rows[$];
  logic table_built = 1'b0;
  int   err_count   = 0;
  int   check_count = 0;
  int   assert_fails;

  rvfi_trace_top #(
    .DEBUG (1)
  ) DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .step_i       (step_i),
    .fetch_i      (fetch_i),
    .fetch_pc_i   (fetch_pc_i),
    .irq_ack_i    (irq_ack_i),
    .irq_id_i     (irq_id_i),
    .dbg_ack_i    (dbg_ack_i),
    .dbg_cause_i  (dbg_cause_i),
    .exc_i        (exc_i),
    .exc_cause_i  (exc_cause_i),
    .rvfi_valid_o (rvfi_valid_o),
    .rvfi_pc_o    (rvfi_pc_o),
    .rvfi_trap_o  (rvfi_trap_o),
    .rvfi_intr_o  (rvfi_intr_o),
    .rvfi_dbg_o   (rvfi_dbg_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Table helpers
  ////////////////////////////////////////

  // Row that expects no report
  task automatic add_quiet(input logic step, input logic fetch, input logic [31:0] pc,
                           input ev_kind_e kind = EV_NONE, input logic [5:0] code = '0);
    row_t r;
    r       = '0;
    r.step  = step;
    r.fetch = fetch;
    r.pc    = pc;
    r.kind  = kind;
    r.code  = code;
    rows.push_back(r);
  endtask

  // Stepping row that expects one retirement report
  task automatic add_retire(input logic fetch, input logic [31:0] pc, input logic [31:0] exp_pc,
                            input rvfi_trap_t exp_trap = '0, input rvfi_intr_t exp_intr = '0,
                            input dbg_cause_e exp_dbg = DBG_CAUSE_NONE);
    row_t r;
    r           = '0;
    r.step      = 1'b1;
    r.fetch     = fetch;
    r.pc        = pc;
    r.exp_valid = 1'b1;
    r.exp_pc    = exp_pc;
    r.exp_trap  = exp_trap;
    r.exp_intr  = exp_intr;
    r.exp_dbg   = exp_dbg;
    rows.push_back(r);
  endtask

  // A fetch on row n retires on row n+4 when every row in between steps
  task automatic build_table();
    // In-order retirement, then a stall of three cycles and one more
    add_quiet(1, 1, 'h100);
    add_quiet(1, 1, 'h104);
    add_quiet(1, 1, 'h108);
    add_quiet(1, 1, 'h10C);
    add_retire(0, 'h0, 'h100);
    add_retire(0, 'h0, 'h104);
    add_quiet(0, 0, 'h0);
    add_quiet(0, 0, 'h0);
    add_quiet(0, 0, 'h0);
    add_retire(1, 'h110, 'h108);
    add_retire(0, 'h0, 'h10C);
    add_quiet(0, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_retire(0, 'h0, 'h110);
    // Interrupt marks 0x208 in IF and drops 0x200 and 0x204
    add_quiet(1, 1, 'h200);
    add_quiet(1, 1, 'h204);
    add_quiet(1, 1, 'h208, EV_IRQ, 6'h0B);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 1, 'h210);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_retire(0, 'h0, 'h208, '0, 7'h6B);
    add_retire(0, 'h0, 'h210);
    // Exception on 0x300 in WB; cause 0x27 gives 0x07 in the entry record
    add_quiet(1, 1, 'h300);
    add_quiet(1, 1, 'h304);
    add_quiet(1, 1, 'h308);
    add_quiet(1, 1, 'h30C);
    add_quiet(0, 0, 'h0, EV_EXC, 6'h27);
    add_quiet(1, 0, 'h0);
    add_retire(1, 'h400, 'h300, 10'h338);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_retire(0, 'h0, 'h400, '0, 7'h47);
    // Halt request marks 0x508 and drops 0x500 and 0x504
    add_quiet(1, 1, 'h500);
    add_quiet(1, 1, 'h504);
    add_quiet(1, 1, 'h508, EV_DBG, 6'(DBG_CAUSE_HALTREQ));
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_quiet(1, 0, 'h0);
    add_retire(0, 'h0, 'h508, '0, '0, DBG_CAUSE_HALTREQ);
  endtask

  ////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////

  task automatic drive_row(input row_t r);
    step_i      <= r.step;
    fetch_i     <= r.fetch;
    fetch_pc_i  <= r.pc;
    irq_ack_i   <= (r.kind == EV_IRQ);
    irq_id_i    <= r.code[4:0];
    dbg_ack_i   <= (r.kind == EV_DBG);
    dbg_cause_i <= dbg_cause_e'(r.code[2:0]);
    exc_i       <= (r.kind == EV_EXC);
    exc_cause_i <= r.code;
  endtask

  task automatic compare(input string name, input int idx, input logic [31:0] got,
                         input logic [31:0] exp);
    check_count++;
    assert (got === exp)
      else begin
        err_count++;
        $display("ERR %s row %0d got 0x%0h expected 0x%0h", name, idx, got, exp);
      end
  endtask

  // Report fields are only meaningful while valid is high
  task automatic check_row(input int idx, input row_t r);
    compare("rvfi_valid_o", idx, rvfi_valid_o, r.exp_valid);
    if (r.exp_valid) begin
      compare("rvfi_pc_o", idx, rvfi_pc_o, r.exp_pc);
      compare("rvfi_trap_o", idx, rvfi_trap_o, r.exp_trap);
      compare("rvfi_intr_o", idx, rvfi_intr_o, r.exp_intr);
      compare("rvfi_dbg_o", idx, rvfi_dbg_o, r.exp_dbg);
    end
  endtask

  initial begin
    rst_ni      = 1'b0;
    step_i      = 1'b0;
    fetch_i     = 1'b0;
    fetch_pc_i  = '0;
    irq_ack_i   = 1'b0;
    irq_id_i    = '0;
    dbg_ack_i   = 1'b0;
    dbg_cause_i = DBG_CAUSE_NONE;
    exc_i       = 1'b0;
    exc_cause_i = '0;
    build_table();
    table_built = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Row i is sampled one edge after it is driven, so its check trails by one cycle
    for (int i = 0; i < rows.size(); i++) begin
      @(posedge clk_i);
      drive_row(rows[i]);
      @(negedge clk_i);
      if (i > 0) begin
        check_row(i - 1, rows[i - 1]);
      end
    end
    @(posedge clk_i);
    drive_row(row_t'('0));
    @(negedge clk_i);
    check_row(rows.size() - 1, rows[rows.size() - 1]);
    // Give the bound checker time to see the last report
    repeat (2) @(posedge clk_i);
    assert_fails = DUT.u_assertions.fail_count;
    $display("Checks %0d, value errors %0d, assertion failures %0d",
             check_count, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (table_built);
    #((rows.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the stimulus table did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

endmodule

// File: rvfi_trace.f
hw/rvfi_trace_pkg.sv
hw/rvfi_event_capture.sv
hw/rvfi_stage_tracker.sv
hw/rvfi_retire_report.sv
hw/rvfi_trace_top.sv
testbench/rvfi_trace_assertions.sv
testbench/rvfi_trace_tb.sv

// File: Bender.yml
package:
  name: rvfi_trace

sources:
  # Package first, then the design units below the top level
  - target: rtl
    files:
      - hw/rvfi_trace_pkg.sv
      - hw/rvfi_event_capture.sv
      - hw/rvfi_stage_tracker.sv
      - hw/rvfi_retire_report.sv
      - hw/rvfi_trace_top.sv

  # Bound checker and testbench top
  - target: test
    files:
      - testbench/rvfi_trace_assertions.sv
      - testbench/rvfi_trace_tb.sv
